/* source/gobou_cfg.svh */
`ifndef GOBOU_CFG_SVH
`define GOBOU_CFG_SVH

// core array
`define GOBOU_CORE    4
`define GOBOU_CORELOG 2

// memory address widths
`define GOBOU_NETSIZE 10
`define GOBOU_IMGSIZE 10

// lengths and counters
`define GOBOU_LWIDTH  10

// sample, weight and bias width
`define GOBOU_DWIDTH  16

// fraction bits dropped after the bias add
`define GOBOU_QBITS   8

`endif

/* source/gobou_pkg.sv */
`include "gobou_cfg.svh"
`default_nettype none

package gobou_pkg;

  // datapath words
  typedef logic signed [`GOBOU_DWIDTH-1:0]     data_t;
  typedef logic signed [2*`GOBOU_DWIDTH+8-1:0] acc_t;

  // addresses, lengths, core index
  typedef logic [`GOBOU_IMGSIZE-1:0] img_addr_t;
  typedef logic [`GOBOU_NETSIZE-1:0] net_addr_t;
  typedef logic [`GOBOU_LWIDTH-1:0]  len_t;
  typedef logic [`GOBOU_CORELOG-1:0] core_sel_t;

  // strobes that follow the data through the cores
  typedef struct packed {
    logic start;
    logic valid;
    logic stop;
  } ctrl_reg;

  // one image memory access
  typedef struct packed {
    logic      we;
    logic      re;
    img_addr_t addr;
    data_t     wdata;
  } mem_req_t;

endpackage

`default_nettype wire

/* source/gobou_ctrl_core.sv */
`include "gobou_cfg.svh"
`default_nettype none

module gobou_ctrl_core (
  input  wire                       clk,
  input  wire                       xrst,
  input  wire gobou_pkg::ctrl_reg   in_ctrl,
  input  wire                       req,
  input  wire gobou_pkg::core_sel_t net_sel,
  input  wire                       net_we,
  input  wire gobou_pkg::net_addr_t net_addr,
  input  wire gobou_pkg::img_addr_t in_offset,
  input  wire gobou_pkg::img_addr_t out_offset,
  input  wire gobou_pkg::net_addr_t net_offset,
  input  wire gobou_pkg::len_t      total_out,
  input  wire gobou_pkg::len_t      total_in,
  input  wire gobou_pkg::data_t     out_wdata,
  output gobou_pkg::ctrl_reg        out_ctrl,
  output logic                      ack,
  output gobou_pkg::mem_req_t       core_mem,
  output logic [`GOBOU_CORE-1:0]    mem_net_we,
  output gobou_pkg::net_addr_t      mem_net_addr,
  output logic                      breg_we,
  output logic                      serial_we
);
  import gobou_pkg::*;

  typedef enum logic [1:0] {
    s_wait, s_weight, s_bias, s_output
  } state_t;

  state_t    state_q;
  len_t      total_in_q;
  len_t      total_out_q;
  len_t      count_in_q;
  len_t      count_out_q;
  img_addr_t in_offset_q;
  img_addr_t out_offset_q;
  img_addr_t out_ptr_q;
  net_addr_t net_offset_q;
  net_addr_t net_ptr_q;
  logic      img_we_q;
  logic [`GOBOU_CORELOG:0] serial_cnt_q;

  logic start_layer;
  logic weight_end;
  logic output_end;
  logic last_group;

  assign start_layer = req && state_q == s_wait;
  assign weight_end  = state_q == s_weight && count_in_q == total_in_q - 1'b1;
  assign output_end  = state_q == s_output && serial_cnt_q == `GOBOU_CORE;
  assign last_group  = count_out_q + len_t'(`GOBOU_CORE) >= total_out_q;

  // ========================================
  // sequencing
  // ========================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state_q <= s_wait;
    end else begin
      case (state_q)
        s_wait:   if (req) state_q <= s_weight;
        s_weight: if (weight_end) state_q <= s_bias;
        s_bias:   state_q <= s_output;
        s_output: if (output_end) state_q <= last_group ? s_wait : s_weight;
        default:  state_q <= s_wait;
      endcase
    end
  end

  // layer setup, held for the whole layer
  always_ff @(posedge clk) begin
    if (start_layer) begin
      total_in_q   <= total_in;
      total_out_q  <= total_out;
      in_offset_q  <= in_offset;
      out_offset_q <= out_offset;
      net_offset_q <= net_offset;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      count_in_q  <= '0;
      count_out_q <= '0;
    end else begin
      if (weight_end) begin
        count_in_q <= '0;
      end else if (state_q == s_weight) begin
        count_in_q <= count_in_q + 1'b1;
      end
      if (start_layer) begin
        count_out_q <= '0;
      end else if (output_end) begin
        count_out_q <= count_out_q + len_t'(`GOBOU_CORE);
      end
    end
  end

  // ========================================
  // image and network addressing
  // ========================================

  // weights and bias of every group sit back to back
  always_ff @(posedge clk) begin
    if (!xrst) begin
      net_ptr_q <= '0;
      out_ptr_q <= '0;
    end else begin
      if (start_layer) begin
        net_ptr_q <= '0;
      end else if (state_q == s_weight || state_q == s_bias) begin
        net_ptr_q <= net_ptr_q + 1'b1;
      end
      if (start_layer) begin
        out_ptr_q <= '0;
      end else if (img_we_q) begin
        out_ptr_q <= out_ptr_q + 1'b1;
      end
    end
  end

  always_comb begin
    core_mem.we    = img_we_q;
    core_mem.re    = state_q == s_weight;
    core_mem.wdata = out_wdata;
    if (state_q == s_output) begin
      core_mem.addr = out_offset_q + out_ptr_q;
    end else begin
      core_mem.addr = in_offset_q + img_addr_t'(count_in_q);
    end
  end

  // host loading goes straight through
  always_comb begin
    for (int i = 0; i < `GOBOU_CORE; i++) begin
      mem_net_we[i] = net_we && net_sel == core_sel_t'(i);
    end
    mem_net_addr = net_we ? net_addr : net_offset_q + net_ptr_q;
  end

  // ========================================
  // strobes and write-back
  // ========================================

  // registered so valid lines up with the read data
  always_ff @(posedge clk) begin
    if (!xrst) begin
      out_ctrl  <= '0;
      breg_we   <= 1'b0;
      serial_we <= 1'b0;
    end else begin
      out_ctrl.start <= state_q == s_weight && count_in_q == '0;
      out_ctrl.valid <= state_q == s_weight;
      out_ctrl.stop  <= state_q == s_bias;
      breg_we        <= state_q == s_bias;
      serial_we      <= in_ctrl.start;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      serial_cnt_q <= '0;
    end else if (serial_we) begin
      serial_cnt_q <= 1;
    end else if (serial_cnt_q == `GOBOU_CORE) begin
      serial_cnt_q <= '0;
    end else if (serial_cnt_q != '0) begin
      serial_cnt_q <= serial_cnt_q + 1'b1;
    end
  end

  // one write per serialized word
  always_ff @(posedge clk) begin
    if (!xrst) begin
      img_we_q <= 1'b0;
    end else begin
      img_we_q <= state_q == s_output
               && (serial_we || (serial_cnt_q != '0 && serial_cnt_q < `GOBOU_CORE));
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      ack <= 1'b1;
    end else if (start_layer) begin
      ack <= 1'b0;
    end else if (output_end && last_group) begin
      ack <= 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (!xrst) !(ack && state_q != s_wait));
  assert property (@(posedge clk) disable iff (!xrst) core_mem.we |-> state_q == s_output);

endmodule

`default_nettype wire

/* source/gobou_mac.sv */
`include "gobou_cfg.svh"
`default_nettype none

module gobou_mac (
  input  wire                     clk,
  input  wire                     xrst,
  input  wire gobou_pkg::ctrl_reg in_ctrl,
  input  wire gobou_pkg::data_t   img_rdata,
  input  wire gobou_pkg::data_t   net_rdata,
  input  wire                     breg_we,
  output gobou_pkg::ctrl_reg      out_ctrl,
  output gobou_pkg::data_t        result
);
  import gobou_pkg::*;

  acc_t       prod;
  acc_t       acc_q;
  acc_t       shifted;
  data_t      bias_q;
  logic [1:0] stop_d;
  logic       held_q;

  assign prod = acc_t'(img_rdata) * acc_t'(net_rdata);

  always_ff @(posedge clk) begin
    if (breg_we) begin
      bias_q <= net_rdata;
    end
    if (in_ctrl.start) begin
      acc_q <= in_ctrl.valid ? prod : '0;
    end else if (in_ctrl.valid) begin
      acc_q <= acc_q + prod;
    end else if (stop_d[0]) begin
      // bias lands one cycle after it was captured
      acc_q <= acc_q + acc_t'(bias_q);
    end
  end

  // stop delayed past the bias add marks the result ready
  always_ff @(posedge clk) begin
    if (!xrst) begin
      stop_d <= '0;
      held_q <= 1'b0;
    end else begin
      stop_d <= {stop_d[0], in_ctrl.stop};
      if (stop_d[1]) begin
        held_q <= 1'b1;
      end else if (in_ctrl.start) begin
        held_q <= 1'b0;
      end
    end
  end

  assign out_ctrl = '{start: stop_d[1], valid: held_q, stop: stop_d[1]};

  assign shifted = acc_q >>> `GOBOU_QBITS;
  assign result  = shifted[`GOBOU_DWIDTH-1:0];

endmodule

`default_nettype wire

/* source/gobou_serial.sv */
`include "gobou_cfg.svh"
`default_nettype none

module gobou_serial (
  input  wire                                     clk,
  input  wire                                     xrst,
  input  wire                                     serial_we,
  input  wire gobou_pkg::data_t [`GOBOU_CORE-1:0] results,
  output gobou_pkg::data_t                        out_wdata
);
  import gobou_pkg::*;

  data_t [`GOBOU_CORE-1:0] shift_q;
  logic [`GOBOU_CORELOG:0] left_q;

  // words still to go out
  always_ff @(posedge clk) begin
    if (!xrst) begin
      left_q <= '0;
    end else if (serial_we) begin
      left_q <= (`GOBOU_CORELOG+1)'(`GOBOU_CORE);
    end else if (left_q != '0) begin
      left_q <= left_q - 1'b1;
    end
  end

  // core 0 leaves first
  always_ff @(posedge clk) begin
    if (serial_we) begin
      shift_q <= results;
    end else if (left_q != '0) begin
      shift_q <= {data_t'(0), shift_q[`GOBOU_CORE-1:1]};
    end
  end

  assign out_wdata = shift_q[0];

endmodule

`default_nettype wire

/* source/img_arbiter.sv */
`include "gobou_cfg.svh"
`default_nettype none

module img_arbiter (
  input  wire                      clk,
  input  wire                      xrst,
  input  wire gobou_pkg::mem_req_t host_mem,
  input  wire gobou_pkg::mem_req_t core_mem,
  input  wire                      busy,
  output gobou_pkg::data_t         host_rdata,
  output gobou_pkg::data_t         core_rdata
);
  import gobou_pkg::*;

  mem_req_t sel;
  logic     grant_core_q;
  data_t    rdata_q;
  data_t    mem [2**`GOBOU_IMGSIZE];

  // ========================================
  // grant
  // ========================================

  // core owns the port for the whole layer
  assign sel = busy ? core_mem : host_mem;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      grant_core_q <= 1'b0;
    end else begin
      grant_core_q <= busy;
    end
  end

  // ========================================
  // single-port image memory
  // ========================================

  always_ff @(posedge clk) begin
    if (sel.we) begin
      mem[sel.addr] <= sel.wdata;
    end
    if (sel.re) begin
      rdata_q <= mem[sel.addr];
    end
  end

  // read data back to last cycle's owner
  assign host_rdata = grant_core_q ? '0 : rdata_q;
  assign core_rdata = grant_core_q ? rdata_q : '0;

  // host access during a layer is dropped
  assert property (@(posedge clk) disable iff (!xrst)
    busy |-> !(host_mem.we || host_mem.re));

endmodule

`default_nettype wire

/* source/gobou_top.sv */
`include "gobou_cfg.svh"
`default_nettype none

module gobou_top (
  input  wire                       clk,
  input  wire                       xrst,
  input  wire                       req,
  input  wire gobou_pkg::img_addr_t in_offset,
  input  wire gobou_pkg::img_addr_t out_offset,
  input  wire gobou_pkg::net_addr_t net_offset,
  input  wire gobou_pkg::len_t      total_in,
  input  wire gobou_pkg::len_t      total_out,
  input  wire                       net_we,
  input  wire gobou_pkg::core_sel_t net_sel,
  input  wire gobou_pkg::net_addr_t net_addr,
  input  wire gobou_pkg::data_t     net_wdata,
  input  wire gobou_pkg::mem_req_t  host_mem,
  output gobou_pkg::data_t          host_rdata,
  output logic                      ack
);
  import gobou_pkg::*;

  ctrl_reg   mac_ctrl;
  ctrl_reg   res_ctrl;
  ctrl_reg   core_ctrl [`GOBOU_CORE];
  mem_req_t  core_mem;
  data_t     core_rdata;
  data_t     out_wdata;
  data_t     net_rdata [`GOBOU_CORE];
  data_t     [`GOBOU_CORE-1:0] results;
  net_addr_t mem_net_addr;
  logic [`GOBOU_CORE-1:0] mem_net_we;
  logic      breg_we;
  logic      serial_we;
  logic      busy;

  assign busy     = !ack;
  assign res_ctrl = core_ctrl[0];

  gobou_ctrl_core u_ctrl (
    .clk, .xrst, .in_ctrl(res_ctrl), .req, .net_sel, .net_we, .net_addr,
    .in_offset, .out_offset, .net_offset, .total_out, .total_in, .out_wdata,
    .out_ctrl(mac_ctrl), .ack, .core_mem, .mem_net_we, .mem_net_addr, .breg_we, .serial_we
  );

  img_arbiter u_arb (
    .clk, .xrst, .host_mem, .core_mem, .busy, .host_rdata, .core_rdata
  );

  // one network memory and one MAC per core
  for (genvar i = 0; i < `GOBOU_CORE; i++) begin : g_core
    data_t net_mem [2**`GOBOU_NETSIZE];

    always_ff @(posedge clk) begin
      if (mem_net_we[i]) begin
        net_mem[mem_net_addr] <= net_wdata;
      end
      net_rdata[i] <= net_mem[mem_net_addr];
    end

    gobou_mac u_mac (
      .clk, .xrst, .in_ctrl(mac_ctrl), .img_rdata(core_rdata), .net_rdata(net_rdata[i]),
      .breg_we, .out_ctrl(core_ctrl[i]), .result(results[i])
    );
  end

  gobou_serial u_serial (
    .clk, .xrst, .serial_we, .results, .out_wdata
  );

endmodule

`default_nettype wire

/* test/gobou_tb.sv */
`include "gobou_cfg.svh"
`default_nettype none

module gobou_tb;
  import gobou_pkg::*;

  localparam int num_layers    = 12;
  localparam int max_in        = 16;
  localparam int max_groups    = 4;
  localparam int max_out       = max_groups * `GOBOU_CORE;
  localparam int img_words     = 2 ** `GOBOU_IMGSIZE;
  // generous bound on one layer's busy time
  localparam int busy_limit    = max_groups * (max_in + `GOBOU_CORE + 12);
  localparam int layer_cycles  = 2 * img_words + max_out * (max_in + 1) + max_in + busy_limit;
  localparam int watchdog_time = (num_layers + 1) * layer_cycles * 20;

  logic      clk;
  logic      xrst;
  logic      req;
  img_addr_t in_offset;
  img_addr_t out_offset;
  net_addr_t net_offset;
  len_t      total_in;
  len_t      total_out;
  logic      net_we;
  core_sel_t net_sel;
  net_addr_t net_addr;
  data_t     net_wdata;
  mem_req_t  host_mem;
  data_t     host_rdata;
  logic      ack;

  integer seed;
  int     value_errs;
  int     proto_errs;
  int     ack_rises;
  int     layers_run;
  logic   ack_prev;

  // reference copy of the image memory and the current layer
  data_t shadow [img_words];
  data_t xin [max_in];
  data_t wt [max_out][max_in];
  data_t bias_val [max_out];

  gobou_top u_dut (
    .clk(clk), .xrst(xrst), .req(req), .in_offset(in_offset), .out_offset(out_offset),
    .net_offset(net_offset), .total_in(total_in), .total_out(total_out), .net_we(net_we),
    .net_sel(net_sel), .net_addr(net_addr), .net_wdata(net_wdata), .host_mem(host_mem),
    .host_rdata(host_rdata), .ack(ack)
  );

  always #10 clk = ~clk;

  // one rise per finished layer
  always @(negedge clk) begin
    if (xrst) begin
      if (ack && !ack_prev) begin
        ack_rises++;
      end
      ack_prev = ack;
    end
  end

  // ========================================
  // host access helpers
  // ========================================

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic host_write(input int addr, input data_t d);
    host_mem = '{we: 1'b1, re: 1'b0, addr: img_addr_t'(addr), wdata: d};
    next_cycle();
    host_mem = '0;
  endtask

  task automatic host_read(input int addr, output data_t d);
    host_mem = '{we: 1'b0, re: 1'b1, addr: img_addr_t'(addr), wdata: '0};
    next_cycle();
    d = host_rdata;
    host_mem = '0;
  endtask

  task automatic net_write(input int sel, input int addr, input data_t d);
    net_we    = 1'b1;
    net_sel   = core_sel_t'(sel);
    net_addr  = net_addr_t'(addr);
    net_wdata = d;
    next_cycle();
    net_we    = 1'b0;
  endtask

  task automatic check_word(input string name, input int addr, input data_t got,
                            input data_t exp);
    assert (got === exp) else begin
      value_errs++;
      $display("ERR %0t %s[%0d]: got %h, expected %h", $time, name, addr, got, exp);
    end
  endtask

  // odd multiplier keeps every address bit in the word
  function automatic data_t fill_word(input int a);
    return data_t'((a * 40503) ^ 'h5a3c);
  endfunction

  task automatic verify_image();
    data_t rd;
    for (int a = 0; a < img_words; a++) begin
      host_read(a, rd);
      check_word("host_rdata", a, rd, shadow[a]);
    end
  endtask

  // ========================================
  // reference model and layer runner
  // ========================================

  // sum of products plus bias, shifted and truncated
  task automatic model_output(input int idx, input int n_in, output data_t y);
    longint sum;
    sum = longint'(bias_val[idx]);
    for (int k = 0; k < n_in; k++) begin
      sum += longint'(wt[idx][k]) * longint'(xin[k]);
    end
    sum = sum >>> `GOBOU_QBITS;
    y = data_t'(sum);
  endtask

  task automatic run_layer(input int groups, input int n_in, input int in_off,
                           input int out_off, input int net_off);
    int    n_out;
    int    base;
    int    waited;
    data_t y;
    n_out = groups * `GOBOU_CORE;
    for (int k = 0; k < n_in; k++) begin
      xin[k] = data_t'($random(seed) % 64);
      shadow[in_off + k] = xin[k];
      host_write(in_off + k, xin[k]);
    end
    // output o lives in core o mod CORE, group o div CORE
    for (int o = 0; o < n_out; o++) begin
      base = net_off + (o / `GOBOU_CORE) * (n_in + 1);
      for (int k = 0; k < n_in; k++) begin
        wt[o][k] = data_t'($random(seed) % 64);
        net_write(o % `GOBOU_CORE, base + k, wt[o][k]);
      end
      bias_val[o] = data_t'($random(seed) % 4096);
      net_write(o % `GOBOU_CORE, base + n_in, bias_val[o]);
    end
    in_offset  = img_addr_t'(in_off);
    out_offset = img_addr_t'(out_off);
    net_offset = net_addr_t'(net_off);
    total_in   = len_t'(n_in);
    total_out  = len_t'(n_out);
    req        = 1'b1;
    next_cycle();
    req        = 1'b0;
    assert (ack === 1'b0) else begin
      proto_errs++;
      $display("%0t: ack did not fall after req", $time);
    end
    waited = 0;
    while (ack !== 1'b1 && waited < busy_limit) begin
      next_cycle();
      waited++;
    end
    assert (ack === 1'b1) else begin
      proto_errs++;
      $display("%0t: ack did not rise within %0d cycles", $time, busy_limit);
    end
    layers_run++;
    for (int o = 0; o < n_out; o++) begin
      model_output(o, n_in, y);
      shadow[out_off + o] = y;
    end
    verify_image();
  endtask

  // ========================================
  // main sequence
  // ========================================

  initial begin
    data_t rd;
    seed       = 32'h6f70_9b75;
    clk        = 1'b0;
    xrst       = 1'b0;
    req        = 1'b0;
    in_offset  = '0;
    out_offset = '0;
    net_offset = '0;
    total_in   = '0;
    total_out  = '0;
    net_we     = 1'b0;
    net_sel    = '0;
    net_addr   = '0;
    net_wdata  = '0;
    host_mem   = '0;
    value_errs = 0;
    proto_errs = 0;
    ack_rises  = 0;
    layers_run = 0;
    ack_prev   = 1'b1;

    repeat (10) @(posedge clk);
    #1;
    xrst = 1'b1;
    next_cycle();

    assert (ack === 1'b1) else begin
      proto_errs++;
      $display("%0t: ack is not high after reset", $time);
    end
    host_write(37, 16'h1234);
    host_read(37, rd);
    check_word("host_rdata", 37, rd, 16'h1234);

    for (int a = 0; a < img_words; a++) begin
      shadow[a] = fill_word(a);
      host_write(a, shadow[a]);
    end
    verify_image();

    // single group, then several groups with a shifted network
    run_layer(1, 8, 0, 512, 0);
    run_layer(3, 1 + $unsigned($random(seed)) % max_in, 100, 700, 77);

    for (int i = 0; i < num_layers - 2; i++) begin
      run_layer(1 + $unsigned($random(seed)) % max_groups,
                1 + $unsigned($random(seed)) % max_in,
                $unsigned($random(seed)) % 256,
                512 + $unsigned($random(seed)) % 256,
                $unsigned($random(seed)) % 128);
    end

    assert (ack_rises == layers_run) else begin
      proto_errs++;
      $display("ack rose %0d times over %0d layers", ack_rises, layers_run);
    end

    $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(watchdog_time);
    $display("watchdog expired at %0t after %0d of %0d layers", $time, layers_run,
             num_layers);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+source
source/gobou_pkg.sv
source/gobou_ctrl_core.sv
source/gobou_mac.sv
source/gobou_serial.sv
source/img_arbiter.sv
source/gobou_top.sv
test/gobou_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = gobou_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
